//--- flist.f
+incdir+.
uart_frame_pkg.sv
uart_fsm_pkg.sv
rx_frame_if.sv
uart_tx_queue.sv
uart_tx.sv
uart_rx.sv
uart_rx_queue.sv
uart_core.sv
tb_uart_core.sv

//--- run.sh
#!/bin/sh
# Compile the testbench with Verilator, run it and look for the pass line in the log.
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module tb_uart_core \
   -o tb_uart_core \
   && ./obj_dir/tb_uart_core > sim.log 2>&1 \
   || echo "run.sh: build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "Regression passed" sim.log \
   && { echo "run.sh: PASS"; exit 0; } \
   || { echo "run.sh: FAIL"; exit 1; }

//--- rx_frame_if.sv
`timescale 1ns/1ps

// One received frame on its way from the receiver to the receive queue.
interface rx_frame_if;

   uart_frame_pkg::data_t data; // Received byte.
   logic parity_err;            // Parity sample disagreed with the data.
   logic frame_err;             // Stop bit was sampled low.
   logic valid;                 // Single-cycle strobe, no back-pressure.

   // Receiver side.
   modport source (
      output data, parity_err, frame_err, valid
   );

   // Receive queue side.
   modport sink (
      input data, parity_err, frame_err, valid
   );

endinterface

//--- tb_uart_core.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module tb_uart_core;

   localparam int cpb          = `UART_CLKS_PER_BIT;
   localparam int frame_cycles = 11 * cpb;                  // Start, 8 data, parity, stop.
   localparam int total_frames = 53;                        // 40 + 1 + 1 + 6 + 5 frames.
   localparam int watchdog_ns  = total_frames * frame_cycles * 8 * 2 + 20000;

   logic                  clk;
   logic                  rst;
   logic                  tx_push;
   uart_frame_pkg::data_t tx_data;
   logic                  tx_full;
   logic                  txd;
   logic                  rxd;
   logic                  rx_pop;
   logic                  rx_avail;
   uart_frame_pkg::data_t rx_data;
   logic                  rx_parity_err;
   logic                  rx_frame_err;
   logic                  rx_overrun;
   logic                  use_gen;  // Selects the frame generator instead of loopback.
   logic                  gen_line; // Serial output of the frame generator.
   integer                seed;
   int                    mismatch_count;
   int                    failure_count;
   logic [9:0]            exp_q[$];  // Expected receive entries as {parity_err, frame_err, data}.
   uart_frame_pkg::data_t line_q[$]; // Bytes expected on txd, oldest first.

   assign rxd = use_gen ? gen_line : txd; // Injected frames or the DUT's own line.

   uart_core dut0 (
      .clk           (clk),
      .rst           (rst),
      .tx_push       (tx_push),
      .tx_data       (tx_data),
      .tx_full       (tx_full),
      .txd           (txd),
      .rxd           (rxd),
      .rx_pop        (rx_pop),
      .rx_avail      (rx_avail),
      .rx_data       (rx_data),
      .rx_parity_err (rx_parity_err),
      .rx_frame_err  (rx_frame_err),
      .rx_overrun    (rx_overrun)
   );

   always #4 clk = ~clk; // 8 ns period.

   task automatic note_bad_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
      mismatch_count++;
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
   endtask

   task automatic log_problem(input string what);
      failure_count++;
      $display("error: %s", what);
   endtask

   // Builds one frame bit by bit, optionally with flipped parity or a low stop bit.
   task automatic send_frame(input uart_frame_pkg::data_t b, input logic bad_par,
                             input logic bad_stop);
      gen_line = 1'b0; // Start bit.
      repeat (cpb) @(negedge clk);
      for (int i = 0; i < `UART_DATA_BITS; i++) begin
         gen_line = b[i]; // LSB goes out first.
         repeat (cpb) @(negedge clk);
      end
      gen_line = (^b) ^ bad_par; // Even parity unless it is meant to be wrong.
      repeat (cpb) @(negedge clk);
      gen_line = !bad_stop;
      repeat (cpb) @(negedge clk);
      gen_line = 1'b1;
      repeat (2 * cpb) @(negedge clk); // Idle gap before the next frame.
   endtask

   // Waits for the head entry, compares it with the model and pops it.
   task automatic pop_and_check(input int max_cycles);
      logic [9:0] exp;
      int         waited;
      waited = 0;
      while (rx_avail !== 1'b1 && waited < max_cycles) begin
         @(negedge clk);
         waited++;
      end
      if (rx_avail !== 1'b1) begin
         log_problem($sformatf("no received byte within %0d cycles", max_cycles));
      end else begin
         if (exp_q.size() == 0) begin
            log_problem($sformatf("received byte 0x%0h that nothing expected", rx_data));
         end else begin
            exp = exp_q.pop_front();
            if (rx_data !== exp[7:0]) note_bad_value("rx_data", 32'(rx_data), 32'(exp[7:0]));
            if (rx_parity_err !== exp[9])
               note_bad_value("rx_parity_err", 32'(rx_parity_err), 32'(exp[9]));
            if (rx_frame_err !== exp[8])
               note_bad_value("rx_frame_err", 32'(rx_frame_err), 32'(exp[8]));
         end
         rx_pop = 1'b1; // One-cycle pop strobe.
         @(negedge clk);
         rx_pop = 1'b0;
      end
   endtask

   // Samples txd at each bit middle and compares the frame with the pushed bytes.
   initial begin : line_monitor
      uart_frame_pkg::data_t exp_byte;
      uart_frame_pkg::data_t seen;
      logic                  start_lvl;
      logic                  par_lvl;
      logic                  stop_lvl;
      forever begin
         @(negedge clk);
         if (rst === 1'b1 && txd === 1'b0) begin
            repeat (cpb / 2 - 1) @(negedge clk); // Half a bit into the start bit.
            start_lvl = txd;
            for (int i = 0; i < `UART_DATA_BITS; i++) begin
               repeat (cpb) @(negedge clk);
               seen[i] = txd;
            end
            repeat (cpb) @(negedge clk);
            par_lvl = txd;
            repeat (cpb) @(negedge clk);
            stop_lvl = txd;
            if (line_q.size() == 0) begin
               log_problem("frame seen on txd with no byte pushed");
            end else begin
               exp_byte = line_q.pop_front();
               if (start_lvl !== 1'b0) note_bad_value("txd start bit", 32'(start_lvl), 32'h0);
               if (seen !== exp_byte) note_bad_value("txd data", 32'(seen), 32'(exp_byte));
               if (par_lvl !== ^exp_byte)
                  note_bad_value("txd parity bit", 32'(par_lvl), 32'(^exp_byte));
               if (stop_lvl !== 1'b1) note_bad_value("txd stop bit", 32'(stop_lvl), 32'h1);
            end
         end
      end
   end

   initial begin : watchdog
      #(watchdog_ns);
      log_problem($sformatf("watchdog expired after %0d ns", watchdog_ns));
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
      $display("Regression failed");
      $finish;
   end

   initial begin : main_seq
      uart_frame_pkg::data_t b;
      clk = 1'b0;
      rst = 1'b0;
      tx_push = 1'b0;
      tx_data = '0;
      rx_pop = 1'b0;
      use_gen = 1'b0;
      gen_line = 1'b1;
      seed = 88675;
      mismatch_count = 0;
      failure_count = 0;
      repeat (3) @(negedge clk); // Reset held for three cycles.
      rst = 1'b1;
      @(negedge clk);
      if (txd !== 1'b1) note_bad_value("txd", 32'(txd), 32'h1);
      if (tx_full !== 1'b0) note_bad_value("tx_full", 32'(tx_full), 32'h0);
      if (rx_avail !== 1'b0) note_bad_value("rx_avail", 32'(rx_avail), 32'h0);
      if (rx_overrun !== 1'b0) note_bad_value("rx_overrun", 32'(rx_overrun), 32'h0);

      fork // Loopback of 40 bytes, spaced at least one frame apart.
         begin : pusher
            uart_frame_pkg::data_t pb;
            int                    gap;
            for (int i = 0; i < 40; i++) begin
               if (tx_full !== 1'b0) note_bad_value("tx_full", 32'(tx_full), 32'h0);
               pb = uart_frame_pkg::data_t'($random(seed));
               line_q.push_back(pb);
               exp_q.push_back({2'b00, pb});
               tx_push = 1'b1;
               tx_data = pb;
               @(negedge clk);
               tx_push = 1'b0;
               gap = frame_cycles + ($random(seed) & 15);
               repeat (gap) @(negedge clk);
            end
         end
         begin : popper
            for (int k = 0; k < 40; k++) pop_and_check(4 * frame_cycles);
         end
      join
      repeat (2 * cpb) @(negedge clk);
      if (line_q.size() != 0) log_problem("bytes pushed but never seen on txd");

      use_gen = 1'b1; // Both sources are idle high here.
      b = uart_frame_pkg::data_t'($random(seed));
      exp_q.push_back({2'b10, b});
      send_frame(b, 1'b1, 1'b0); // Inverted parity.
      pop_and_check(frame_cycles);
      b = uart_frame_pkg::data_t'($random(seed));
      exp_q.push_back({2'b01, b});
      send_frame(b, 1'b0, 1'b1); // Low stop bit.
      pop_and_check(frame_cycles);

      if (rx_overrun !== 1'b0) note_bad_value("rx_overrun", 32'(rx_overrun), 32'h0);
      for (int j = 0; j < 6; j++) begin
         b = uart_frame_pkg::data_t'($random(seed));
         if (j < 4) exp_q.push_back({2'b00, b}); // Frames five and six are lost.
         send_frame(b, 1'b0, 1'b0);
      end
      if (rx_overrun !== 1'b1) note_bad_value("rx_overrun", 32'(rx_overrun), 32'h1);
      repeat (4) pop_and_check(frame_cycles);
      if (rx_avail !== 1'b0) note_bad_value("rx_avail", 32'(rx_avail), 32'h0);
      if (rx_overrun !== 1'b1) note_bad_value("rx_overrun", 32'(rx_overrun), 32'h1);

      use_gen = 1'b0;
      @(negedge clk);
      for (int j = 0; j < 5; j++) begin // Back-to-back pushes while idle.
         b = uart_frame_pkg::data_t'($random(seed));
         line_q.push_back(b);
         exp_q.push_back({2'b00, b});
         tx_push = 1'b1;
         tx_data = b;
         @(negedge clk);
      end
      if (tx_full !== 1'b1) note_bad_value("tx_full", 32'(tx_full), 32'h1);
      tx_data = uart_frame_pkg::data_t'($random(seed)); // Sixth push meets a full queue.
      @(negedge clk);
      tx_push = 1'b0;
      repeat (5) pop_and_check(3 * frame_cycles);
      repeat (2 * frame_cycles) @(negedge clk); // Room for a sixth frame that must not come.
      if (rx_avail !== 1'b0) note_bad_value("rx_avail", 32'(rx_avail), 32'h0);
      if (line_q.size() != 0) log_problem("bytes pushed but never seen on txd");
      if (exp_q.size() != 0) log_problem("expected entries never received");

      $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
      if (mismatch_count == 0 && failure_count == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

//--- uart_core.sv
`timescale 1ns/1ps

module uart_core (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  tx_push,
   input  uart_frame_pkg::data_t tx_data,
   output logic                  tx_full,
   output logic                  txd,
   input  logic                  rxd,
   input  logic                  rx_pop,
   output logic                  rx_avail,
   output uart_frame_pkg::data_t rx_data,
   output logic                  rx_parity_err,
   output logic                  rx_frame_err,
   output logic                  rx_overrun
);

   uart_frame_pkg::data_t q_data;  // Head byte from the transmit queue.
   logic                  q_valid; // Transmit queue holds a byte.
   logic                  q_ready; // Transmitter is idle.

   rx_frame_if rx_frm (); // Receiver to receive queue.

   uart_tx_queue tx_queue0 (
      .clk       (clk),
      .rst       (rst),
      .push      (tx_push),
      .push_data (tx_data),
      .full      (tx_full),
      .tx_valid  (q_valid),
      .tx_data   (q_data),
      .tx_ready  (q_ready)
   );

   uart_tx tx0 (
      .clk      (clk),
      .rst      (rst),
      .tx_valid (q_valid),
      .tx_data  (q_data),
      .tx_ready (q_ready),
      .txd      (txd)
   );

   uart_rx rx0 (
      .clk (clk),
      .rst (rst),
      .rxd (rxd),
      .frm (rx_frm.source)
   );

   uart_rx_queue rx_queue0 (
      .clk        (clk),
      .rst        (rst),
      .frm        (rx_frm.sink),
      .pop        (rx_pop),
      .avail      (rx_avail),
      .data       (rx_data),
      .parity_err (rx_parity_err),
      .frame_err  (rx_frame_err),
      .overrun    (rx_overrun)
   );

endmodule

//--- uart_frame_pkg.sv
`include "uart_settings.svh"

// Types for the serial frame, its timing counters and the queue bookkeeping.
package uart_frame_pkg;

   // One data word as it leaves or enters the shift path.
   typedef logic [`UART_DATA_BITS-1:0] data_t;

   // Position of the data bit now on the line.
   typedef logic [2:0] bit_idx_t;

   // Clock count inside one bit period.
   // Four bits hold any period up to 16 clocks.
   typedef logic [3:0] baud_cnt_t;

   // Read or write slot of a queue.
   typedef logic [`UART_QUEUE_AW-1:0] qptr_t;

   // Fill level of a queue.
   // The extra top bit lets a full queue be told apart from an empty one.
   typedef logic [`UART_QUEUE_AW:0] qcount_t;

endpackage

//--- uart_fsm_pkg.sv
// State encodings for the two frame controllers.
// The literals carry a tx_ or rx_ prefix so both enums can live in one package.
package uart_fsm_pkg;

   typedef enum logic [2:0] {
      tx_idle,       // Line held high, waiting for a byte.
      tx_start_bit,  // Driving the low start bit.
      tx_data_bits,  // Shifting data out LSB first.
      tx_parity_bit, // Driving the parity bit.
      tx_stop_bit    // Driving the high stop bit.
   } tx_state_t;

   typedef enum logic [2:0] {
      rx_idle,       // Waiting for a falling edge on the line.
      rx_start_bit,  // Counting to the middle of the start bit.
      rx_data_bits,  // Sampling data bits at their middles.
      rx_parity_bit, // Sampling the parity bit.
      rx_stop_bit    // Sampling the stop bit.
   } rx_state_t;

endpackage

//--- uart_rx.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_rx (
   input logic       clk,
   input logic       rst,
   input logic       rxd,
   rx_frame_if.source frm
);

   uart_fsm_pkg::rx_state_t   state;      // Current frame phase.
   uart_fsm_pkg::rx_state_t   next_state;
   uart_frame_pkg::data_t     shifter;    // Data bits gathered LSB first.
   uart_frame_pkg::bit_idx_t  bit_idx;    // Data bit to be sampled next.
   uart_frame_pkg::baud_cnt_t baud_cnt;   // Clocks since the last sample point.
   logic rxd_meta;                        // First synchronizer stage.
   logic rxd_sync;                        // Second stage, safe to use.
   logic rxd_prev;                        // Previous synchronized level.
   logic start_edge;                      // High to low change on the line.
   logic half_tick;                       // Middle of the start bit reached.
   logic full_tick;                       // Middle of a later bit reached.
   logic last_bit;                        // Final data bit is being sampled.
   logic par_sample;                      // Parity bit as seen on the line.
   logic par_expect;                      // Parity bit the data calls for.
   logic valid_q;
   logic parity_err_q;
   logic frame_err_q;

   assign start_edge = rxd_prev && !rxd_sync;
   assign half_tick  = (baud_cnt == uart_frame_pkg::baud_cnt_t'(`UART_CLKS_PER_BIT / 2 - 1));
   assign full_tick  = (baud_cnt == uart_frame_pkg::baud_cnt_t'(`UART_CLKS_PER_BIT - 1));
   assign last_bit   = (bit_idx == uart_frame_pkg::bit_idx_t'(`UART_DATA_BITS - 1));
   assign par_expect = (`UART_PARITY == 1) ? ~^shifter : ^shifter;

   always_ff @(posedge clk) begin
      if (!rst) begin
         rxd_meta <= 1'b1; // Start from the idle line level.
         rxd_sync <= 1'b1;
         rxd_prev <= 1'b1;
      end else begin
         rxd_meta <= rxd;
         rxd_sync <= rxd_meta;
         rxd_prev <= rxd_sync;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst) begin
         baud_cnt <= '0;
      end else if (state == uart_fsm_pkg::rx_idle) begin
         baud_cnt <= '0; // Held at zero until a frame begins.
      end else if ((state == uart_fsm_pkg::rx_start_bit) ? half_tick : full_tick) begin
         baud_cnt <= '0; // Restart at every sample point.
      end else begin
         baud_cnt <= baud_cnt + 1'b1;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         uart_fsm_pkg::rx_idle: begin
            if (start_edge) begin
               next_state = uart_fsm_pkg::rx_start_bit;
            end
         end
         uart_fsm_pkg::rx_start_bit: begin
            if (half_tick) begin
               // A high line at mid start bit was only a glitch.
               next_state = rxd_sync ? uart_fsm_pkg::rx_idle : uart_fsm_pkg::rx_data_bits;
            end
         end
         uart_fsm_pkg::rx_data_bits: begin
            if (full_tick && last_bit) begin
               next_state = (`UART_PARITY != 0) ? uart_fsm_pkg::rx_parity_bit
                                                : uart_fsm_pkg::rx_stop_bit;
            end
         end
         uart_fsm_pkg::rx_parity_bit: begin
            if (full_tick) begin
               next_state = uart_fsm_pkg::rx_stop_bit;
            end
         end
         uart_fsm_pkg::rx_stop_bit: begin
            if (full_tick) begin
               next_state = uart_fsm_pkg::rx_idle; // Wait for the next falling edge.
            end
         end
         default: next_state = uart_fsm_pkg::rx_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst) begin
         state   <= uart_fsm_pkg::rx_idle;
         bit_idx <= '0;
         valid_q <= 1'b0;
      end else begin
         state   <= next_state;
         valid_q <= (state == uart_fsm_pkg::rx_stop_bit) && full_tick; // One pulse per frame.
         if (state == uart_fsm_pkg::rx_idle) begin
            bit_idx <= '0;
         end else if (state == uart_fsm_pkg::rx_data_bits && full_tick) begin
            bit_idx <= bit_idx + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (state == uart_fsm_pkg::rx_data_bits && full_tick) begin
         shifter <= {rxd_sync, shifter[`UART_DATA_BITS-1:1]}; // New bit enters at the top.
      end
      if (state == uart_fsm_pkg::rx_parity_bit && full_tick) begin
         par_sample <= rxd_sync;
      end
      if (state == uart_fsm_pkg::rx_stop_bit && full_tick) begin
         frame_err_q  <= !rxd_sync; // Stop bit must be high.
         parity_err_q <= (`UART_PARITY != 0) && (par_sample != par_expect);
      end
   end

   assign frm.data       = shifter; // Stable until the next frame's data bits.
   assign frm.parity_err = parity_err_q;
   assign frm.frame_err  = frame_err_q;
   assign frm.valid      = valid_q;

   // A frame is reported exactly once.
   a_valid_pulse: assert property (@(posedge clk) disable iff (!rst)
      frm.valid |=> !frm.valid);

endmodule

//--- uart_rx_queue.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_rx_queue (
   input  logic                  clk,
   input  logic                  rst,
   rx_frame_if.sink              frm,
   input  logic                  pop,
   output logic                  avail,
   output uart_frame_pkg::data_t data,
   output logic                  parity_err,
   output logic                  frame_err,
   output logic                  overrun
);

   uart_frame_pkg::data_t   data_mem [`UART_QUEUE_DEPTH]; // Received bytes.
   logic                    perr_mem [`UART_QUEUE_DEPTH]; // Parity flag per entry.
   logic                    ferr_mem [`UART_QUEUE_DEPTH]; // Framing flag per entry.
   uart_frame_pkg::qptr_t   wr_ptr;
   uart_frame_pkg::qptr_t   rd_ptr;
   uart_frame_pkg::qcount_t count;
   logic                    full;
   logic                    do_push;
   logic                    do_pop;

   assign full    = (count == uart_frame_pkg::qcount_t'(`UART_QUEUE_DEPTH));
   assign do_push = frm.valid && !full; // Frames arriving while full are dropped.
   assign do_pop  = pop && avail;       // A pop on an empty queue does nothing.

   // The head entry falls through to the outputs.
   assign avail      = (count != '0);
   assign data       = data_mem[rd_ptr];
   assign parity_err = perr_mem[rd_ptr];
   assign frame_err  = ferr_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (do_push) begin
         data_mem[wr_ptr] <= frm.data;
         perr_mem[wr_ptr] <= frm.parity_err;
         ferr_mem[wr_ptr] <= frm.frame_err;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         overrun <= 1'b0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (frm.valid && full) begin
            overrun <= 1'b1; // Sticky until reset.
         end
      end
   end

   // Once a frame has been lost the flag stays up for good.
   a_overrun_sticky: assert property (@(posedge clk) disable iff (!rst)
      overrun |=> overrun);

endmodule

//--- uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// Clock cycles per serial bit.
// A short period keeps simulation of whole frames fast.
`define UART_CLKS_PER_BIT 8

// Data bits carried in one frame, sent LSB first.
`define UART_DATA_BITS 8

// Parity mode code.
// 0 means no parity bit, 1 means odd parity, 2 means even parity.
`define UART_PARITY 2

// Entries held in the transmit queue and in the receive queue.
`define UART_QUEUE_DEPTH 4

// Pointer width for a queue of UART_QUEUE_DEPTH entries.
`define UART_QUEUE_AW 2

`endif

//--- uart_tx.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tx (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  tx_valid,
   input  uart_frame_pkg::data_t tx_data,
   output logic                  tx_ready,
   output logic                  txd
);

   uart_fsm_pkg::tx_state_t   state;      // Current frame phase.
   uart_fsm_pkg::tx_state_t   next_state;
   uart_frame_pkg::data_t     shadow;     // Byte being sent, held for the whole frame.
   uart_frame_pkg::bit_idx_t  bit_idx;    // Data bit now on the line.
   uart_frame_pkg::baud_cnt_t baud_cnt;   // Clocks spent in the current bit.
   logic                      baud_tick;  // Last clock of the current bit.
   logic                      par_value;  // Parity bit for the latched byte.
   logic                      last_bit;   // The final data bit is on the line.

   assign baud_tick = (baud_cnt == uart_frame_pkg::baud_cnt_t'(`UART_CLKS_PER_BIT - 1));
   assign last_bit  = (bit_idx == uart_frame_pkg::bit_idx_t'(`UART_DATA_BITS - 1));
   assign tx_ready  = (state == uart_fsm_pkg::tx_idle); // New bytes only between frames.

   // Odd mode inverts the XOR so the total count of ones is odd.
   assign par_value = (`UART_PARITY == 1) ? ~^shadow : ^shadow;

   always_ff @(posedge clk) begin
      if (!rst) begin
         baud_cnt <= '0;
      end else if (state == uart_fsm_pkg::tx_idle || baud_tick) begin
         baud_cnt <= '0; // Held at zero in idle and restarted for each bit.
      end else begin
         baud_cnt <= baud_cnt + 1'b1;
      end
   end

   always_comb begin
      next_state = state; // Stay put unless a bit period ends.
      case (state)
         uart_fsm_pkg::tx_idle: begin
            if (tx_valid && tx_ready) begin
               next_state = uart_fsm_pkg::tx_start_bit; // Handshake starts a frame.
            end
         end
         uart_fsm_pkg::tx_start_bit: begin
            if (baud_tick) begin
               next_state = uart_fsm_pkg::tx_data_bits;
            end
         end
         uart_fsm_pkg::tx_data_bits: begin
            if (baud_tick && last_bit) begin
               next_state = (`UART_PARITY != 0) ? uart_fsm_pkg::tx_parity_bit
                                                : uart_fsm_pkg::tx_stop_bit;
            end
         end
         uart_fsm_pkg::tx_parity_bit: begin
            if (baud_tick) begin
               next_state = uart_fsm_pkg::tx_stop_bit;
            end
         end
         uart_fsm_pkg::tx_stop_bit: begin
            if (baud_tick) begin
               next_state = uart_fsm_pkg::tx_idle; // Ready again after the stop bit.
            end
         end
         default: next_state = uart_fsm_pkg::tx_idle;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst) begin
         state   <= uart_fsm_pkg::tx_idle;
         bit_idx <= '0;
      end else begin
         state <= next_state;
         if (state == uart_fsm_pkg::tx_idle) begin
            bit_idx <= '0; // Every frame starts at bit 0.
         end else if (state == uart_fsm_pkg::tx_data_bits && baud_tick) begin
            bit_idx <= bit_idx + 1'b1; // Step to the next data bit.
         end
      end
   end

   always_ff @(posedge clk) begin
      if (tx_valid && tx_ready) begin
         shadow <= tx_data; // Keep the byte stable while the queue moves on.
      end
   end

   always_comb begin
      case (state)
         uart_fsm_pkg::tx_start_bit:  txd = 1'b0;            // Start condition.
         uart_fsm_pkg::tx_data_bits:  txd = shadow[bit_idx]; // LSB goes first.
         uart_fsm_pkg::tx_parity_bit: txd = par_value;
         default:                     txd = 1'b1;            // Idle and stop are high.
      endcase
   end

   // The line rests high whenever no frame is in progress.
   a_idle_high: assert property (@(posedge clk) disable iff (!rst)
      (state == uart_fsm_pkg::tx_idle) |-> txd);

endmodule

//--- uart_tx_queue.sv
`timescale 1ns/1ps
`include "uart_settings.svh"

module uart_tx_queue (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  push,
   input  uart_frame_pkg::data_t push_data,
   output logic                  full,
   output logic                  tx_valid,
   output uart_frame_pkg::data_t tx_data,
   input  logic                  tx_ready
);

   uart_frame_pkg::data_t   mem [`UART_QUEUE_DEPTH]; // Byte storage.
   uart_frame_pkg::qptr_t   wr_ptr;                   // Next slot to write.
   uart_frame_pkg::qptr_t   rd_ptr;                   // Slot shown to the transmitter.
   uart_frame_pkg::qcount_t count;                    // Bytes currently held.
   logic                    do_push;
   logic                    do_pop;

   assign full     = (count == uart_frame_pkg::qcount_t'(`UART_QUEUE_DEPTH)); // No room left.
   assign tx_valid = (count != '0);   // Head byte is offered as soon as one is stored.
   assign tx_data  = mem[rd_ptr];     // Head of the queue, valid while tx_valid is high.
   assign do_push  = push && !full;   // A push into a full queue is lost.
   assign do_pop   = tx_valid && tx_ready; // Byte leaves on the handshake.

   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data; // Write the new byte at the tail.
      end
   end

   always_ff @(posedge clk) begin
      if (!rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= wr_ptr + 1'b1; // Pointers wrap at the depth.
         end
         if (do_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1; // Push only.
            2'b01:   count <= count - 1'b1; // Pop only.
            default: count <= count;        // Neither, or both at once.
         endcase
      end
   end

   // The fill level stays within the storage across any mix of pushes and pops.
   a_count_bound: assert property (@(posedge clk) disable iff (!rst)
      count <= uart_frame_pkg::qcount_t'(`UART_QUEUE_DEPTH));

endmodule
